//--- verilog/istream_pkg.sv
package istream_pkg;

    // --------------------------------------------------
    // sizes
    // --------------------------------------------------

    localparam int CHUNKS_PER_SET = 8;
    localparam int WINDOW_CHUNKS  = 2 * CHUNKS_PER_SET;
    localparam int DEQ_WAYS       = 4;

    // --------------------------------------------------
    // types
    // --------------------------------------------------

    // one 2-byte halfword, lsb2 == 2'b11 marks uncompressed
    typedef struct packed {
        logic [13:0] upper;
        logic [1:0]  lsb2;
    } chunk_t;

    // fetch block as delivered
    typedef struct packed {
        logic [CHUNKS_PER_SET-1:0]   valid;
        chunk_t [CHUNKS_PER_SET-1:0] chunks;
        logic [31:0]                 after_pc;
    } enq_block_t;

    // two oldest sets, head set in the low half
    typedef struct packed {
        logic [WINDOW_CHUNKS-1:0]   valid;
        logic [WINDOW_CHUNKS-1:0]   marker;
        logic [WINDOW_CHUNKS-1:0]   uncompressed;
        chunk_t [WINDOW_CHUNKS-1:0] chunks;
        logic [31:0]                head_pc;
        logic [31:0]                head_after_pc;
        logic                       head_present;
        logic                       second_present;
    } deq_window_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        logic        uncompressed;
    } way_out_t;

    // head sets retired this cycle
    typedef enum logic [1:0] {
        deq_none,
        deq_one,
        deq_two
    } deq_action_e;

endpackage

//--- verilog/way_select.sv
`timescale 1ns/1ps

module way_select (
    input  istream_pkg::deq_window_t              window,
    input  logic [istream_pkg::WINDOW_CHUNKS-1:0] req_in,
    output logic [istream_pkg::WINDOW_CHUNKS-1:0] req_out,
    output logic [istream_pkg::WINDOW_CHUNKS-1:0] ack,
    output logic                                  valid,
    output istream_pkg::way_out_t                 inst
);

    localparam int WC = istream_pkg::WINDOW_CHUNKS;

    logic [WC-1:0] lower_onehot;
    logic [WC-1:0] above_mask;
    logic [WC-1:0] upper_req;
    logic [WC-1:0] upper_onehot;
    logic          lower_found;
    logic          upper_found;
    logic          lower_uncomp;

    logic [3:0]          lower_idx;
    istream_pkg::chunk_t lower_chunk;
    istream_pkg::chunk_t upper_chunk;

    // --------------------------------------------------
    // lower half from markers and upper half from valid
    // --------------------------------------------------

    assign lower_onehot = req_in & (~req_in + 1'b1);
    assign lower_found  = |req_in;
    assign lower_uncomp = |(window.uncompressed & lower_onehot);

    // strictly above the lower half and empty when no lower
    assign above_mask   = ~(lower_onehot | (lower_onehot - 1'b1));
    assign upper_req    = window.valid & above_mask;
    assign upper_onehot = upper_req & (~upper_req + 1'b1);
    assign upper_found  = |upper_req;

    assign valid   = lower_found && (!lower_uncomp || upper_found);
    assign ack     = lower_onehot | (lower_uncomp ? upper_onehot : '0);
    assign req_out = req_in & ~lower_onehot;

    always_comb begin
        lower_idx   = '0;
        lower_chunk = '0;
        upper_chunk = '0;
        for (int i = 0; i < WC; i++) begin
            if (lower_onehot[i]) begin
                lower_idx   = 4'(i);
                lower_chunk = window.chunks[i];
            end
            if (upper_onehot[i]) begin
                upper_chunk = window.chunks[i];
            end
        end
    end

    // --------------------------------------------------
    // output assembly
    // --------------------------------------------------

    always_comb begin
        // second set's base is the head set's after PC
        if (lower_idx[3]) begin
            inst.pc = {window.head_after_pc[31:4], lower_idx[2:0], 1'b0};
        end else begin
            inst.pc = {window.head_pc[31:4], lower_idx[2:0], 1'b0};
        end
        inst.inst         = lower_uncomp ? {upper_chunk, lower_chunk} : {16'h0, lower_chunk};
        inst.uncompressed = lower_uncomp;
    end

    // ack covers at most two chunks and only valid ones
    always_comb begin
        a_ack_two: assert final ($countones(ack) <= 2 && (ack & ~window.valid) == '0)
            else $error("way acked more than two chunks or an invalid chunk");
    end

endmodule

//--- verilog/deq_advance.sv
`timescale 1ns/1ps

module deq_advance (
    input  logic [istream_pkg::DEQ_WAYS-1:0][istream_pkg::WINDOW_CHUNKS-1:0] ack_by_way,
    input  logic [istream_pkg::DEQ_WAYS-1:0]                                 valid_by_way,
    input  istream_pkg::deq_window_t                                         window,
    output logic [istream_pkg::WINDOW_CHUNKS-1:0]                            ack_vec,
    output istream_pkg::deq_action_e                                         action
);

    localparam int CPS = istream_pkg::CHUNKS_PER_SET;
    localparam int WC  = istream_pkg::WINDOW_CHUNKS;

    logic [WC-1:0] remaining;
    logic          head_done;
    logic          second_done;

    // --------------------------------------------------
    // merge acks of the valid ways
    // --------------------------------------------------

    always_comb begin
        ack_vec = '0;
        for (int w = 0; w < istream_pkg::DEQ_WAYS; w++) begin
            if (valid_by_way[w]) begin
                ack_vec = ack_vec | ack_by_way[w];
            end
        end
    end

    // what is left of each set after this cycle
    assign remaining = window.valid & ~ack_vec;

    assign head_done   = window.head_present && !(|remaining[CPS-1:0]);
    assign second_done = window.second_present && !(|remaining[WC-1:CPS]);

    // --------------------------------------------------
    // retirement
    // --------------------------------------------------

    always_comb begin
        action = istream_pkg::deq_none;
        if (head_done) begin
            // second set only goes together with the head
            if (second_done) begin
                action = istream_pkg::deq_two;
            end else begin
                action = istream_pkg::deq_one;
            end
        end
    end

    // valid ways start at way 0 with no gaps
    always_comb begin
        a_way_prefix: assert final ((valid_by_way & (valid_by_way + 1'b1)) == '0)
            else $error("valid ways are not a prefix");
    end

endmodule

//--- verilog/set_queue.sv
`timescale 1ns/1ps

module set_queue #(
    parameter int          ISTREAM_SETS = 8,
    parameter logic [31:0] INIT_PC      = 32'h8000_0000
) (
    input  logic CLK,
    input  logic nRST,

    input  logic                    valid_SENQ,
    input  istream_pkg::enq_block_t block_SENQ,
    output logic                    stall_SENQ,

    input  logic                                   stall_SDEQ,
    input  logic                                   restart,
    input  logic [31:0]                            restart_PC,
    input  logic [istream_pkg::WINDOW_CHUNKS-1:0]  ack_vec,
    input  istream_pkg::deq_action_e               action,
    output istream_pkg::deq_window_t               window
);

    localparam int IDX_W = $clog2(ISTREAM_SETS);
    localparam int CPS   = istream_pkg::CHUNKS_PER_SET;

    typedef struct packed {
        logic             wrap;
        logic [IDX_W-1:0] idx;
    } ptr_t;

    // --------------------------------------------------
    // state
    // --------------------------------------------------

    istream_pkg::chunk_t [ISTREAM_SETS-1:0][CPS-1:0] chunk_mem;
    logic [ISTREAM_SETS-1:0][31:0]                   after_pc_mem;
    logic [ISTREAM_SETS-1:0][CPS-1:0]                uncomp_mem;

    logic [ISTREAM_SETS-1:0][CPS-1:0] valid_q, next_valid;
    logic [ISTREAM_SETS-1:0][CPS-1:0] marker_q, next_marker;

    ptr_t        enq_ptr, head_ptr, second_ptr;
    logic [31:0] head_pc;
    logic        carry_q;

    logic [IDX_W:0] occupancy;
    logic           head_present, second_present;
    logic           accept, deq_en;

    logic [CPS-1:0] enq_uncomp, enq_marker;
    logic [CPS:0]   carry;

    assign second_ptr     = head_ptr + 1'b1;
    assign occupancy      = enq_ptr - head_ptr;
    assign head_present   = occupancy != '0;
    assign second_present = occupancy > 1;

    // full when indices meet with opposite wrap
    assign stall_SENQ = (enq_ptr.idx == head_ptr.idx) && (enq_ptr.wrap != head_ptr.wrap);

    assign accept = valid_SENQ && !stall_SENQ && !restart;
    assign deq_en = !stall_SDEQ && !restart;

    // --------------------------------------------------
    // start marking with carry across blocks
    // --------------------------------------------------

    always_comb begin
        carry[0] = carry_q;
        for (int i = 0; i < CPS; i++) begin
            enq_uncomp[i] = block_SENQ.chunks[i].lsb2 == 2'b11;
            enq_marker[i] = 1'b0;
            carry[i+1]    = carry[i];
            if (block_SENQ.valid[i]) begin
                // waiting upper half is never a start
                enq_marker[i] = !carry[i];
                carry[i+1]    = !carry[i] && enq_uncomp[i];
            end
        end
    end

    // --------------------------------------------------
    // window onto the two oldest sets
    // --------------------------------------------------

    always_comb begin
        window.valid          = {valid_q[second_ptr.idx] & {CPS{second_present}},
                                 valid_q[head_ptr.idx] & {CPS{head_present}}};
        window.marker         = {marker_q[second_ptr.idx] & {CPS{second_present}},
                                 marker_q[head_ptr.idx] & {CPS{head_present}}};
        window.uncompressed   = {uncomp_mem[second_ptr.idx], uncomp_mem[head_ptr.idx]};
        window.chunks         = {chunk_mem[second_ptr.idx], chunk_mem[head_ptr.idx]};
        window.head_pc        = head_pc;
        window.head_after_pc  = after_pc_mem[head_ptr.idx];
        window.head_present   = head_present;
        window.second_present = second_present;
    end

    // acked chunks drop out and a new block overwrites its set
    always_comb begin
        next_valid  = valid_q;
        next_marker = marker_q;
        if (deq_en) begin
            next_valid[head_ptr.idx]    = valid_q[head_ptr.idx] & ~ack_vec[CPS-1:0];
            next_marker[head_ptr.idx]   = marker_q[head_ptr.idx] & ~ack_vec[CPS-1:0];
            next_valid[second_ptr.idx]  = valid_q[second_ptr.idx] & ~ack_vec[2*CPS-1:CPS];
            next_marker[second_ptr.idx] = marker_q[second_ptr.idx] & ~ack_vec[2*CPS-1:CPS];
        end
        if (accept) begin
            next_valid[enq_ptr.idx]  = block_SENQ.valid;
            next_marker[enq_ptr.idx] = enq_marker;
        end
    end

    // --------------------------------------------------
    // registers
    // --------------------------------------------------

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            enq_ptr  <= '0;
            head_ptr <= '0;
            head_pc  <= INIT_PC;
            carry_q  <= 1'b0;
            valid_q  <= '0;
            marker_q <= '0;
        end else if (restart) begin
            enq_ptr  <= '0;
            head_ptr <= '0;
            head_pc  <= restart_PC;
            carry_q  <= 1'b0;
            valid_q  <= '0;
            marker_q <= '0;
        end else begin
            valid_q  <= next_valid;
            marker_q <= next_marker;
            if (accept) begin
                enq_ptr <= enq_ptr + 1'b1;
                carry_q <= carry[CPS];
            end
            if (deq_en) begin
                case (action)
                    istream_pkg::deq_one: begin
                        head_ptr <= head_ptr + 1'b1;
                        head_pc  <= after_pc_mem[head_ptr.idx];
                    end
                    istream_pkg::deq_two: begin
                        head_ptr <= head_ptr + 2'd2;
                        head_pc  <= after_pc_mem[second_ptr.idx];
                    end
                    default: begin
                        head_ptr <= head_ptr;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (accept) begin
            chunk_mem[enq_ptr.idx]    <= block_SENQ.chunks;
            after_pc_mem[enq_ptr.idx] <= block_SENQ.after_pc;
            uncomp_mem[enq_ptr.idx]   <= enq_uncomp;
        end
    end

    // an enqueue into a full ring would push occupancy past the set count
    a_full_no_enq: assert property (@(posedge CLK) disable iff (!nRST)
        occupancy <= ISTREAM_SETS)
        else $error("ring holds more sets than it has");

    // retiring two sets needs two sets
    a_two_needs_second: assert property (@(posedge CLK) disable iff (!nRST)
        action == istream_pkg::deq_two |-> second_present)
        else $error("deq_two with second set absent");

endmodule

//--- verilog/istream_top.sv
`timescale 1ns/1ps

module istream_top #(
    parameter int          ISTREAM_SETS = 8,
    parameter logic [31:0] INIT_PC      = 32'h8000_0000
) (
    input  logic CLK,
    input  logic nRST,

    // enqueue side
    input  logic                    valid_SENQ,
    input  istream_pkg::enq_block_t block_SENQ,
    output logic                    stall_SENQ,

    // dequeue side
    output logic                                            valid_SDEQ,
    output logic [istream_pkg::DEQ_WAYS-1:0]                valid_by_way_SDEQ,
    output istream_pkg::way_out_t [istream_pkg::DEQ_WAYS-1:0] inst_by_way_SDEQ,
    input  logic                                            stall_SDEQ,

    // control
    input  logic        restart,
    input  logic [31:0] restart_PC
);

    istream_pkg::deq_window_t window;

    // remaining start markers, passed from way to way
    logic [istream_pkg::DEQ_WAYS:0][istream_pkg::WINDOW_CHUNKS-1:0] req_chain;

    logic [istream_pkg::DEQ_WAYS-1:0][istream_pkg::WINDOW_CHUNKS-1:0] ack_by_way;
    logic [istream_pkg::WINDOW_CHUNKS-1:0] ack_vec;
    istream_pkg::deq_action_e              action;

    set_queue #(
        .ISTREAM_SETS (ISTREAM_SETS),
        .INIT_PC      (INIT_PC)
    ) queue0 (
        .CLK        (CLK),
        .nRST       (nRST),
        .valid_SENQ (valid_SENQ),
        .block_SENQ (block_SENQ),
        .stall_SENQ (stall_SENQ),
        .stall_SDEQ (stall_SDEQ),
        .restart    (restart),
        .restart_PC (restart_PC),
        .ack_vec    (ack_vec),
        .action     (action),
        .window     (window)
    );

    assign req_chain[0] = window.marker;

    for (genvar w = 0; w < istream_pkg::DEQ_WAYS; w++) begin : g_way
        way_select way0 (
            .window  (window),
            .req_in  (req_chain[w]),
            .req_out (req_chain[w+1]),
            .ack     (ack_by_way[w]),
            .valid   (valid_by_way_SDEQ[w]),
            .inst    (inst_by_way_SDEQ[w])
        );
    end

    deq_advance advance0 (
        .ack_by_way   (ack_by_way),
        .valid_by_way (valid_by_way_SDEQ),
        .window       (window),
        .ack_vec      (ack_vec),
        .action       (action)
    );

    // ways form a prefix, so way 0 says it all
    assign valid_SDEQ = valid_by_way_SDEQ[0];

endmodule

//--- verification/tb_istream.sv
`timescale 1ns/1ps

module tb_istream;

    localparam int          SETS     = 8;
    localparam logic [31:0] START_PC = 32'h8000_0000;
    localparam int          WAYS     = istream_pkg::DEQ_WAYS;
    localparam int          LIMIT    = 400;

    logic                             CLK;
    logic                             nRST;
    logic                             valid_SENQ;
    istream_pkg::enq_block_t          block_SENQ;
    logic                             stall_SENQ;
    logic                             valid_SDEQ;
    logic [WAYS-1:0]                  valid_by_way_SDEQ;
    istream_pkg::way_out_t [WAYS-1:0] inst_by_way_SDEQ;
    logic                             stall_SDEQ;
    logic                             restart;
    logic [31:0]                      restart_PC;

    // reference instruction stream with the oldest first
    logic [31:0] ref_pc[$];
    logic [31:0] ref_inst[$];
    logic [31:0] exp_pc[WAYS];
    logic [31:0] exp_inst[WAYS];
    int          exp_count;
    logic        ref_carry;
    logic [15:0] ref_lower;
    logic [31:0] ref_lower_pc;

    // effect of the coming rising edge
    int                      pend_pops;
    logic                    pend_restart;
    logic                    pend_push;
    istream_pkg::enq_block_t pend_block;
    logic [31:0]             pend_base;

    logic [31:0]             rng;
    logic [31:0]             next_base;
    logic                    must_be_open;
    logic                    must_be_full;
    istream_pkg::enq_block_t spare_blk;

    istream_top #(
        .ISTREAM_SETS (SETS),
        .INIT_PC      (START_PC)
    ) dut0 (
        .CLK               (CLK),
        .nRST              (nRST),
        .valid_SENQ        (valid_SENQ),
        .block_SENQ        (block_SENQ),
        .stall_SENQ        (stall_SENQ),
        .valid_SDEQ        (valid_SDEQ),
        .valid_by_way_SDEQ (valid_by_way_SDEQ),
        .inst_by_way_SDEQ  (inst_by_way_SDEQ),
        .stall_SDEQ        (stall_SDEQ),
        .restart           (restart),
        .restart_PC        (restart_PC)
    );

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Testbench failed");
        $fatal(1);
    endtask

    // --------------------------------------------------
    // reference model
    // --------------------------------------------------

    // a start is any valid chunk that is not a pending upper half
    task automatic push_block(input istream_pkg::enq_block_t blk, input logic [31:0] base);
        logic [31:0] pc;
        logic [15:0] half;
        for (int i = 0; i < istream_pkg::CHUNKS_PER_SET; i++) begin
            pc   = base + 32'(2 * i);
            half = blk.chunks[i];
            if (blk.valid[i]) begin
                if (ref_carry) begin
                    ref_pc.push_back(ref_lower_pc);
                    ref_inst.push_back({half, ref_lower});
                    ref_carry = 1'b0;
                end else if (half[1:0] == 2'b11) begin
                    ref_carry    = 1'b1;
                    ref_lower    = half;
                    ref_lower_pc = pc;
                end else begin
                    ref_pc.push_back(pc);
                    ref_inst.push_back({16'h0, half});
                end
            end
        end
    endtask

    task automatic apply_edge();
        if (pend_restart) begin
            ref_pc.delete();
            ref_inst.delete();
            ref_carry = 1'b0;
        end else begin
            repeat (pend_pops) begin
                if (ref_pc.size() > 0) begin
                    void'(ref_pc.pop_front());
                    void'(ref_inst.pop_front());
                end
            end
            if (pend_push) begin
                push_block(pend_block, pend_base);
            end
        end
        exp_count = (ref_pc.size() < WAYS) ? ref_pc.size() : WAYS;
        for (int w = 0; w < WAYS; w++) begin
            exp_pc[w]   = (w < exp_count) ? ref_pc[w] : '0;
            exp_inst[w] = (w < exp_count) ? ref_inst[w] : '0;
        end
    endtask

    // --------------------------------------------------
    // stimulus
    // --------------------------------------------------

    task automatic drive_cycle(input logic enq, input istream_pkg::enq_block_t blk,
                               input logic dstall, input logic rst, input logic [31:0] rst_pc);
        @(negedge CLK);
        apply_edge();
        // decode takes every valid way unless stalled
        pend_pops    = (dstall || rst) ? 0 : $countones(valid_by_way_SDEQ);
        pend_push    = enq && !stall_SENQ && !rst;
        pend_restart = rst;
        pend_block   = blk;
        pend_base    = next_base;
        if (rst) begin
            next_base = rst_pc;
        end else if (pend_push) begin
            next_base = blk.after_pc;
        end
        valid_SENQ = enq;
        block_SENQ = blk;
        stall_SDEQ = dstall;
        restart    = rst;
        restart_PC = rst_pc;
    endtask

    task automatic idle(input int n, input logic hold);
        repeat (n) drive_cycle(1'b0, '0, hold, 1'b0, '0);
    endtask

    // kind 0 is compressed only, 1 has random widths and 2 starts an uncompressed one at chunk 7
    task automatic make_block(input int kind, input logic [7:0] mask,
                              output istream_pkg::enq_block_t blk);
        logic [1:0] low;
        blk.valid = mask;
        for (int i = 0; i < istream_pkg::CHUNKS_PER_SET; i++) begin
            rng = next_random(rng);
            low = rng[1:0];
            if (kind == 0 || (kind == 2 && i < 7)) begin
                low = (low == 2'b11) ? 2'b01 : low;
            end else if (kind == 2) begin
                low = 2'b11;
            end
            blk.chunks[i] = {rng[17:4], low};
        end
        rng = next_random(rng);
        // mostly sequential with a taken jump now and then
        blk.after_pc = (rng[2:0] == 3'd0) ? {rng[31:8], 8'h0} : next_base + 32'd16;
    endtask

    task automatic offer_block(input int kind, input logic [7:0] mask,
                               input logic hold, input logic jitter);
        istream_pkg::enq_block_t blk;
        int tries;
        make_block(kind, mask, blk);
        tries = 0;
        do begin
            rng = next_random(rng);
            drive_cycle(1'b1, blk, hold || (jitter && rng[3]), 1'b0, '0);
            tries++;
            if (tries > LIMIT) begin
                report_failure("timed out offering a block to the buffer");
            end
        end while (!pend_push);
    endtask

    task automatic wait_drained();
        int n;
        n = 0;
        do begin
            drive_cycle(1'b0, '0, 1'b0, 1'b0, '0);
            n++;
            if (n > LIMIT) begin
                report_failure("timed out waiting for the buffer to drain");
            end
        end while (ref_pc.size() > 0);
    endtask

    // --------------------------------------------------
    // checks
    // --------------------------------------------------

    a_reset: assert property (@(posedge CLK) !nRST |-> !stall_SENQ && !valid_SDEQ)
        else report_failure($sformatf("[FAIL] stall_SENQ = %h, valid_SDEQ = %h in reset",
            $sampled(stall_SENQ), $sampled(valid_SDEQ)));

    a_open: assert property (@(posedge CLK) disable iff (!nRST) must_be_open |-> !stall_SENQ)
        else report_failure($sformatf("[FAIL] stall_SENQ = %h, expected 0",
            $sampled(stall_SENQ)));

    a_full: assert property (@(posedge CLK) disable iff (!nRST) must_be_full |-> stall_SENQ)
        else report_failure($sformatf("[FAIL] stall_SENQ = %h, expected 1",
            $sampled(stall_SENQ)));

    a_prefix: assert property (@(posedge CLK) disable iff (!nRST)
        (valid_by_way_SDEQ & (valid_by_way_SDEQ + 4'd1)) == 4'd0)
        else report_failure($sformatf("[FAIL] valid_by_way_SDEQ = %h is not a prefix",
            $sampled(valid_by_way_SDEQ)));

    a_way0: assert property (@(posedge CLK) disable iff (!nRST)
        valid_SDEQ == valid_by_way_SDEQ[0])
        else report_failure($sformatf("[FAIL] valid_SDEQ = %h, expected %h",
            $sampled(valid_SDEQ), $sampled(valid_by_way_SDEQ[0])));

    for (genvar w = 0; w < WAYS; w++) begin : g_way_check
        a_count: assert property (@(posedge CLK) disable iff (!nRST)
            valid_by_way_SDEQ[w] |-> exp_count > w)
            else report_failure($sformatf("[FAIL] valid_by_way_SDEQ = %h, reference holds %h",
                $sampled(valid_by_way_SDEQ), exp_count));

        a_inst: assert property (@(posedge CLK) disable iff (!nRST)
            valid_by_way_SDEQ[w] |-> inst_by_way_SDEQ[w].inst == exp_inst[w])
            else report_failure($sformatf("[FAIL] inst_by_way_SDEQ[%0d].inst = %h, expected %h",
                w, $sampled(inst_by_way_SDEQ[w].inst), exp_inst[w]));

        a_pc: assert property (@(posedge CLK) disable iff (!nRST)
            valid_by_way_SDEQ[w] |-> inst_by_way_SDEQ[w].pc == exp_pc[w])
            else report_failure($sformatf("[FAIL] inst_by_way_SDEQ[%0d].pc = %h, expected %h",
                w, $sampled(inst_by_way_SDEQ[w].pc), exp_pc[w]));

        a_width: assert property (@(posedge CLK) disable iff (!nRST)
            valid_by_way_SDEQ[w] |->
                inst_by_way_SDEQ[w].uncompressed == (exp_inst[w][1:0] == 2'b11))
            else report_failure($sformatf(
                "[FAIL] inst_by_way_SDEQ[%0d].uncompressed = %h, expected %h",
                w, $sampled(inst_by_way_SDEQ[w].uncompressed), exp_inst[w][1:0] == 2'b11));
    end

    // --------------------------------------------------
    // test sequence
    // --------------------------------------------------

    initial begin
        rng          = 32'h61dd;
        next_base    = START_PC;
        nRST         = 1'b0;
        valid_SENQ   = 1'b0;
        block_SENQ   = '0;
        stall_SDEQ   = 1'b0;
        restart      = 1'b0;
        restart_PC   = '0;
        must_be_open = 1'b0;
        must_be_full = 1'b0;
        ref_carry    = 1'b0;
        ref_lower    = '0;
        ref_lower_pc = '0;
        exp_count    = 0;
        pend_pops    = 0;
        pend_restart = 1'b0;
        pend_push    = 1'b0;
        pend_block   = '0;
        pend_base    = '0;
        for (int w = 0; w < WAYS; w++) begin
            exp_pc[w]   = '0;
            exp_inst[w] = '0;
        end
        repeat (8) @(negedge CLK);
        nRST = 1'b1;

        must_be_open = 1'b1;
        idle(3, 1'b0);
        repeat (6) offer_block(0, 8'hff, 1'b0, 1'b0);
        wait_drained();

        // split instruction waits for its upper half
        offer_block(2, 8'hff, 1'b0, 1'b0);
        idle(3, 1'b0);
        offer_block(0, 8'hff, 1'b0, 1'b0);
        wait_drained();
        must_be_open = 1'b0;

        repeat (40) begin
            rng = next_random(rng);
            case (rng[5:4])
                2'd0:    offer_block(2, 8'hff, 1'b0, 1'b1);
                2'd1:    offer_block(1, rng[15:8] | 8'h01, 1'b0, 1'b1);
                default: offer_block(1, 8'hff, 1'b0, 1'b1);
            endcase
            rng = next_random(rng);
            if (rng[1:0] == 2'd0) begin
                idle(3, rng[2]);
            end
        end
        offer_block(0, 8'hff, 1'b0, 1'b0);
        wait_drained();

        // fill the ring behind a decode stall
        must_be_open = 1'b1;
        repeat (SETS) offer_block(0, 8'hff, 1'b1, 1'b0);
        must_be_open = 1'b0;
        make_block(1, 8'hff, spare_blk);
        drive_cycle(1'b1, spare_blk, 1'b1, 1'b0, '0);
        must_be_full = 1'b1;
        repeat (4) drive_cycle(1'b1, spare_blk, 1'b1, 1'b0, '0);
        must_be_full = 1'b0;
        wait_drained();

        // restart with stale sets still queued
        repeat (3) offer_block(1, 8'hff, 1'b1, 1'b0);
        make_block(0, 8'hff, spare_blk);
        drive_cycle(1'b1, spare_blk, 1'b1, 1'b1, 32'h0000_4a30);
        must_be_open = 1'b1;
        idle(4, 1'b0);
        must_be_open = 1'b0;
        repeat (5) begin
            rng = next_random(rng);
            offer_block(1, rng[15:8] | 8'h01, 1'b0, 1'b1);
        end
        offer_block(0, 8'hff, 1'b0, 1'b0);
        wait_drained();

        $display("Testbench passed");
        $finish;
    end

endmodule

//--- flist.f
verilog/istream_pkg.sv
verilog/way_select.sv
verilog/deq_advance.sv
verilog/set_queue.sv
verilog/istream_top.sv
verification/tb_istream.sv

//--- run_sim.sh
#!/bin/sh
# build and run the instruction stream buffer testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert -Wno-fatal \
    --top-module tb_istream \
    -f flist.f \
    -o tb_istream_sim

# the log decides the result, so the run itself may end either way
./obj_dir/tb_istream_sim 2>&1 | tee sim.log

if grep -q "^Testbench passed$" sim.log; then
    echo "simulation result: PASS (see sim.log)"
    exit 0
fi

echo "simulation result: FAIL (see sim.log)"
exit 1
